// File: source/spi_master_pkg.sv
package spi_master_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Frame geometry
    ////////////////////////////////////////////////////////////////////////////

    localparam int SPI_ADDRESS_WIDTH = 15;
    localparam int SPI_DATA_WIDTH    = 16;
    localparam int SPI_FRAME_BITS    = SPI_ADDRESS_WIDTH + 1 + SPI_DATA_WIDTH;

    typedef logic [SPI_ADDRESS_WIDTH-1:0] spi_address_t;
    typedef logic [SPI_DATA_WIDTH-1:0]    spi_data_t;
    typedef logic [SPI_FRAME_BITS-1:0]    spi_frame_t;
    typedef logic [15:0]                  spi_divider_t;
    typedef logic [5:0]                   spi_bit_count_t;

    // Field order matches the order on the wire, so the struct is the frame
    typedef struct packed {
        spi_address_t address;
        logic         read_write;
        spi_data_t    data;
    } spi_request_t;

    typedef struct packed {
        logic         clock_polarity;
        logic         clock_phase;
        spi_divider_t divider;
    } spi_config_t;

    typedef enum logic [1:0] {
        state_idle,
        state_select,
        state_shift,
        state_stop
    } spi_state_t;

endpackage

// File: source/spi_request_stage.sv
`timescale 1ns/10ps

module spi_request_stage (
    input  logic                         clock,
    input  logic                         reset_n,
    input  logic                         enable,
    input  spi_master_pkg::spi_request_t request,
    input  spi_master_pkg::spi_config_t  configuration,
    input  logic                         busy,
    output logic                         start,
    output logic                         divider_tick,
    output spi_master_pkg::spi_request_t held_request,
    output spi_master_pkg::spi_config_t  held_config
);
    import spi_master_pkg::*;

    logic         accept;
    spi_divider_t divider_count;

    // Requests arriving during a transaction are dropped
    assign accept = enable && !busy;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            start       <= 1'b0;
            held_config <= '0;
        end else begin
            start <= accept;
            if (accept) begin
                held_config <= configuration;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            held_request <= request;
        end
    end

    // Divider restarts with each transaction, giving a fixed bit period
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            divider_count <= '0;
        end else if (start || divider_tick) begin
            divider_count <= '0;
        end else begin
            divider_count <= divider_count + 1'b1;
        end
    end

    assign divider_tick = (divider_count == held_config.divider);

    // A new start only after the sequencer went idle, and busy follows it
    start_outside_busy: assert property (
        @(posedge clock) disable iff (!reset_n)
        start |-> !$past(busy) ##1 (busy && !start)
    );

endmodule

// File: source/spi_bit_sequencer.sv
`timescale 1ns/10ps

module spi_bit_sequencer (
    input  logic                        clock,
    input  logic                        reset_n,
    input  logic                        start,
    input  logic                        divider_tick,
    input  spi_master_pkg::spi_config_t held_config,
    input  logic                        read_write,
    output logic                        serial_clock,
    output logic                        slave_select,
    output logic                        busy,
    output logic                        load,
    output logic                        shift_out,
    output logic                        sample_in,
    output logic                        capture,
    output logic                        read_data_valid
);
    import spi_master_pkg::*;

    spi_state_t     state;
    logic [1:0]     quarter;
    spi_bit_count_t bit_count;
    logic           internal_clock;
    logic           last_bit;

    assign busy         = start || (state != state_idle);
    assign serial_clock = internal_clock ^ held_config.clock_polarity;
    assign last_bit     = (bit_count == spi_bit_count_t'(SPI_FRAME_BITS - 1));

    ////////////////////////////////////////////////////////////////////////////
    // Transaction FSM, four divider ticks per frame bit
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state           <= state_idle;
            quarter         <= '0;
            bit_count       <= '0;
            internal_clock  <= 1'b0;
            slave_select    <= 1'b1;
            load            <= 1'b0;
            shift_out       <= 1'b0;
            sample_in       <= 1'b0;
            capture         <= 1'b0;
            read_data_valid <= 1'b0;
        end else begin
            load            <= 1'b0;
            shift_out       <= 1'b0;
            sample_in       <= 1'b0;
            capture         <= 1'b0;
            // Valid lines up with the read data register update
            read_data_valid <= capture;

            case (state)
                state_idle: begin
                    if (start) begin
                        state     <= state_select;
                        quarter   <= '0;
                        bit_count <= '0;
                    end
                end
                state_select: begin
                    if (divider_tick) begin
                        slave_select <= 1'b0;
                        load         <= 1'b1;
                        // CPHA 0 puts the first bit out before the first edge
                        shift_out    <= !held_config.clock_phase;
                        state        <= state_shift;
                    end
                end
                state_shift: begin
                    if (divider_tick) begin
                        quarter <= quarter + 1'b1;
                        case (quarter)
                            2'd0: begin
                                sample_in <= held_config.clock_phase && (bit_count != '0);
                            end
                            2'd1: begin
                                internal_clock <= 1'b1;
                                sample_in      <= !held_config.clock_phase;
                                shift_out      <= held_config.clock_phase;
                            end
                            2'd3: begin
                                internal_clock <= 1'b0;
                                shift_out      <= !held_config.clock_phase;
                                if (last_bit) begin
                                    bit_count <= '0;
                                    state     <= state_stop;
                                end else begin
                                    bit_count <= bit_count + 1'b1;
                                end
                            end
                            default: ;
                        endcase
                    end
                end
                state_stop: begin
                    if (divider_tick) begin
                        quarter <= quarter + 1'b1;
                        case (quarter)
                            2'd0: sample_in <= held_config.clock_phase;
                            2'd1: begin
                                slave_select <= 1'b1;
                                // Drained register, so this returns the line low
                                shift_out    <= 1'b1;
                                capture      <= read_write;
                            end
                            2'd3: state <= state_idle;
                            default: ;
                        endcase
                    end
                end
                default: state <= state_idle;
            endcase
        end
    end

    select_within_busy: assert property (
        @(posedge clock) disable iff (!reset_n)
        !slave_select |-> busy
    );

    valid_only_on_read: assert property (
        @(posedge clock) disable iff (!reset_n)
        read_data_valid |-> read_write
    );

endmodule

// File: source/spi_shift_unit.sv
`timescale 1ns/10ps

module spi_shift_unit (
    input  logic                         clock,
    input  logic                         reset_n,
    input  spi_master_pkg::spi_request_t held_request,
    input  logic                         load,
    input  logic                         shift_out,
    input  logic                         sample_in,
    input  logic                         capture,
    input  logic                         master_in_slave_out,
    output logic                         master_out_slave_in,
    output spi_master_pkg::spi_data_t    read_data
);
    import spi_master_pkg::*;

    spi_frame_t request_frame;
    spi_frame_t out_shift;
    spi_frame_t in_shift;

    assign request_frame = held_request;

    ////////////////////////////////////////////////////////////////////////////
    // Outgoing side
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (load && shift_out) begin
            out_shift <= {request_frame[SPI_FRAME_BITS-2:0], 1'b0};
        end else if (load) begin
            out_shift <= request_frame;
        end else if (shift_out) begin
            out_shift <= {out_shift[SPI_FRAME_BITS-2:0], 1'b0};
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            master_out_slave_in <= 1'b0;
        end else if (capture) begin
            master_out_slave_in <= 1'b0;
        end else if (load && shift_out) begin
            // First bit straight from the request
            master_out_slave_in <= request_frame[SPI_FRAME_BITS-1];
        end else if (shift_out) begin
            master_out_slave_in <= out_shift[SPI_FRAME_BITS-1];
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Incoming side
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (sample_in) begin
            in_shift <= {in_shift[SPI_FRAME_BITS-2:0], master_in_slave_out};
        end
    end

    // Only the trailing data bits of the frame are kept
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            read_data <= '0;
        end else if (capture) begin
            read_data <= in_shift[SPI_DATA_WIDTH-1:0];
        end
    end

endmodule

// File: source/spi_master.sv
`timescale 1ns/10ps

module spi_master (
    input  logic                         clock,
    input  logic                         reset_n,
    input  logic                         enable,
    input  spi_master_pkg::spi_request_t request,
    input  spi_master_pkg::spi_config_t  configuration,
    input  logic                         master_in_slave_out,
    output logic                         serial_clock,
    output logic                         slave_select,
    output logic                         master_out_slave_in,
    output logic                         busy,
    output spi_master_pkg::spi_data_t    read_data,
    output logic                         read_data_valid
);
    import spi_master_pkg::*;

    logic         start;
    logic         divider_tick;
    spi_request_t held_request;
    spi_config_t  held_config;
    logic         load;
    logic         shift_out;
    logic         sample_in;
    logic         capture;

    spi_request_stage request_stage (
        .clock         (clock),
        .reset_n       (reset_n),
        .enable        (enable),
        .request       (request),
        .configuration (configuration),
        .busy          (busy),
        .start         (start),
        .divider_tick  (divider_tick),
        .held_request  (held_request),
        .held_config   (held_config)
    );

    spi_bit_sequencer bit_sequencer (
        .clock           (clock),
        .reset_n         (reset_n),
        .start           (start),
        .divider_tick    (divider_tick),
        .held_config     (held_config),
        .read_write      (held_request.read_write),
        .serial_clock    (serial_clock),
        .slave_select    (slave_select),
        .busy            (busy),
        .load            (load),
        .shift_out       (shift_out),
        .sample_in       (sample_in),
        .capture         (capture),
        .read_data_valid (read_data_valid)
    );

    spi_shift_unit shift_unit (
        .clock               (clock),
        .reset_n             (reset_n),
        .held_request        (held_request),
        .load                (load),
        .shift_out           (shift_out),
        .sample_in           (sample_in),
        .capture             (capture),
        .master_in_slave_out (master_in_slave_out),
        .master_out_slave_in (master_out_slave_in),
        .read_data           (read_data)
    );

endmodule

// File: sim/spi_slave_model.sv
`timescale 1ns/10ps

module spi_slave_model (
    input  logic                       serial_clock,
    input  logic                       slave_select,
    input  logic                       master_out_slave_in,
    input  logic                       clock_polarity,
    input  logic                       clock_phase,
    input  spi_master_pkg::spi_frame_t response,
    output logic                       master_in_slave_out,
    output spi_master_pkg::spi_frame_t received,
    output int                         received_bits
);
    import spi_master_pkg::*;

    spi_frame_t response_shift;
    logic       leading;

    task automatic drive_next_bit();
        master_in_slave_out = response_shift[SPI_FRAME_BITS-1];
        response_shift      = response_shift << 1;
    endtask

    initial begin
        master_in_slave_out = 1'b0;
        response_shift      = '0;
    end

    // New response word per frame, CPHA 0 puts its first bit out at once
    always @(negedge slave_select) begin
        response_shift = response;
        received       = '0;
        received_bits  = 0;
        if (!clock_phase) begin
            drive_next_bit();
        end
    end

    always @(serial_clock) begin
        if (!slave_select) begin
            leading = (serial_clock != clock_polarity);
            if (leading != clock_phase) begin
                received      = {received[SPI_FRAME_BITS-2:0], master_out_slave_in};
                received_bits = received_bits + 1;
            end else begin
                drive_next_bit();
            end
        end
    end

endmodule

// File: sim/tb_spi_master.sv
`timescale 1ns/10ps

module tb_spi_master;
    import spi_master_pkg::*;

    localparam int          TEST_COUNT     = 24;
    localparam int          MAX_DIVIDER    = 5;
    localparam int          TIMEOUT_CYCLES =
        (TEST_COUNT + 1) * (SPI_FRAME_BITS + 3) * 4 * (MAX_DIVIDER + 1) + 2000;
    localparam logic [31:0] LFSR_SEED      = 32'hb613;

    logic         clock;
    logic         reset_n;
    logic         enable;
    spi_request_t request;
    spi_config_t  configuration;
    logic         master_in_slave_out;
    logic         serial_clock;
    logic         slave_select;
    logic         master_out_slave_in;
    logic         busy;
    spi_data_t    read_data;
    logic         read_data_valid;
    spi_frame_t   received;
    int           received_bits;

    logic [31:0]  lfsr_state;
    spi_request_t cur_request;
    spi_config_t  cur_config;
    spi_frame_t   cur_response;
    string        cur_name;
    spi_request_t active_request;
    spi_config_t  active_config;
    spi_frame_t   active_response;
    string        active_name;
    logic         prev_busy;
    logic         prev_serial_clock;
    logic         have_edge;
    int           last_edge_cycle;
    int           leading_edges;
    int           valid_pulses;
    int           transactions_done;
    int           read_pulses_total;
    int           reads_started;
    int           error_count;
    int           cycle_count;

    spi_master UUT (
        .clock               (clock),
        .reset_n             (reset_n),
        .enable              (enable),
        .request             (request),
        .configuration       (configuration),
        .master_in_slave_out (master_in_slave_out),
        .serial_clock        (serial_clock),
        .slave_select        (slave_select),
        .master_out_slave_in (master_out_slave_in),
        .busy                (busy),
        .read_data           (read_data),
        .read_data_valid     (read_data_valid)
    );

    spi_slave_model slave (
        .serial_clock        (serial_clock),
        .slave_select        (slave_select),
        .master_out_slave_in (master_out_slave_in),
        .clock_polarity      (cur_config.clock_polarity),
        .clock_phase         (cur_config.clock_phase),
        .response            (cur_response),
        .master_in_slave_out (master_in_slave_out),
        .received            (received),
        .received_bits       (received_bits)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Random source and reference model
    ////////////////////////////////////////////////////////////////////////////

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    task automatic take_random(input int count, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value      = {value[30:0], lfsr_state[0]};
        end
    endtask

    // Address first, then the read/write bit, then data, all MSB first
    function automatic spi_frame_t expected_frame(input spi_request_t req);
        return {req.address, req.read_write, req.data};
    endfunction

    function automatic spi_data_t expected_read_data(input spi_frame_t response);
        return response[SPI_DATA_WIDTH-1:0];
    endfunction

    function automatic spi_divider_t divider_for(input int index);
        case (index)
            0: return 16'd0;
            1: return 16'd1;
            default: return spi_divider_t'(MAX_DIVIDER);
        endcase
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////

    task automatic start_transaction(input logic read_write, input logic [1:0] mode,
                                     input spi_divider_t divider);
        logic [31:0] bits;
        take_random(SPI_ADDRESS_WIDTH, bits);
        cur_request.address = bits[SPI_ADDRESS_WIDTH-1:0];
        take_random(SPI_DATA_WIDTH, bits);
        cur_request.data       = bits[SPI_DATA_WIDTH-1:0];
        cur_request.read_write = read_write;
        take_random(SPI_FRAME_BITS, bits);
        cur_response              = bits;
        cur_config.clock_polarity = mode[1];
        cur_config.clock_phase    = mode[0];
        cur_config.divider        = divider;
        cur_name = $sformatf("%s mode %0d divider %0d", read_write ? "read" : "write",
                             mode, divider);
        if (read_write) begin
            reads_started++;
        end
        @(negedge clock);
        request       = cur_request;
        configuration = cur_config;
        enable        = 1'b1;
        @(negedge clock);
        enable = 1'b0;
    endtask

    task automatic wait_done();
        do begin
            @(negedge clock);
        end while (busy);
        repeat (2) @(negedge clock);
    endtask

    task automatic check_reset_state();
        logic [20:0] outputs;
        outputs = {busy, read_data_valid, master_out_slave_in, serial_clock, slave_select,
                   read_data};
        assert (outputs == 21'h010000) else begin
            $display("error reset state: expected %h actual %h", 21'h010000, outputs);
            error_count++;
        end
    endtask

    // Second request must be dropped while the first one runs
    task automatic run_overlapped_enable();
        int done_before;
        done_before = transactions_done;
        start_transaction(1'b1, 2'd1, 16'd1);
        repeat (20) @(negedge clock);
        assert (busy) else begin
            $display("DUT was not busy when the second enable was driven");
            error_count++;
        end
        request = ~cur_request;
        enable  = 1'b1;
        @(negedge clock);
        enable = 1'b0;
        wait_done();
        repeat (100) @(negedge clock);
        assert (transactions_done == done_before + 1 && !busy) else begin
            $display("error enable while busy: expected %0d actual %0d transactions",
                     1, transactions_done - done_before);
            error_count++;
        end
    endtask

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    initial begin
        reset_n           = 1'b0;
        enable            = 1'b0;
        request           = '0;
        configuration     = '0;
        cur_request       = '0;
        cur_config        = '0;
        cur_response      = '0;
        cur_name          = "idle";
        active_config     = '0;
        active_name       = "idle";
        prev_busy         = 1'b0;
        have_edge         = 1'b0;
        transactions_done = 0;
        read_pulses_total = 0;
        reads_started     = 0;
        error_count       = 0;
        lfsr_state        = LFSR_SEED;
        repeat (2) @(negedge clock);
        reset_n = 1'b1;
        @(negedge clock);
        check_reset_state();
        for (int i = 0; i < TEST_COUNT; i++) begin
            start_transaction(1'((i / 4) % 2), 2'(i % 4), divider_for((i / 4) % 3));
            wait_done();
        end
        run_overlapped_enable();
        assert (transactions_done == TEST_COUNT + 1) else begin
            $display("error totals transactions: expected %0d actual %0d",
                     TEST_COUNT + 1, transactions_done);
            error_count++;
        end
        assert (read_pulses_total == reads_started) else begin
            $display("error totals read data pulses: expected %0d actual %0d",
                     reads_started, read_pulses_total);
            error_count++;
        end
        $display("Transactions %0d, read data pulses %0d, errors %0d",
                 transactions_done, read_pulses_total, error_count);
        if (error_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Compare
    ////////////////////////////////////////////////////////////////////////////

    always @(negedge clock) begin
        if (reset_n) begin
            if (busy && !prev_busy) begin
                active_request  = cur_request;
                active_config   = cur_config;
                active_response = cur_response;
                active_name     = cur_name;
                leading_edges   = 0;
                valid_pulses    = 0;
                have_edge       = 1'b0;
            end
            if (slave_select) begin
                assert (serial_clock == active_config.clock_polarity) else begin
                    $display("error %s idle clock: expected %b actual %b", active_name,
                             active_config.clock_polarity, serial_clock);
                    error_count++;
                end
            end else if (serial_clock != prev_serial_clock) begin
                if (have_edge) begin
                    assert (cycle_count - last_edge_cycle ==
                            2 * (int'(active_config.divider) + 1)) else begin
                        $display("error %s half period: expected %0d actual %0d", active_name,
                                 2 * (int'(active_config.divider) + 1),
                                 cycle_count - last_edge_cycle);
                        error_count++;
                    end
                end
                if (serial_clock != active_config.clock_polarity) begin
                    leading_edges++;
                end
                have_edge       = 1'b1;
                last_edge_cycle = cycle_count;
            end
            if (read_data_valid) begin
                valid_pulses++;
                read_pulses_total++;
                assert (read_data == expected_read_data(active_response)) else begin
                    $display("error %s read data: expected %h actual %h", active_name,
                             expected_read_data(active_response), read_data);
                    error_count++;
                end
            end
            if (prev_busy && !busy) begin
                transactions_done++;
                assert (received == expected_frame(active_request)) else begin
                    $display("error %s frame: expected %h actual %h", active_name,
                             expected_frame(active_request), received);
                    error_count++;
                end
                assert (received_bits == SPI_FRAME_BITS) else begin
                    $display("error %s received bits: expected %0d actual %0d", active_name,
                             SPI_FRAME_BITS, received_bits);
                    error_count++;
                end
                assert (leading_edges == SPI_FRAME_BITS) else begin
                    $display("error %s clock periods: expected %0d actual %0d", active_name,
                             SPI_FRAME_BITS, leading_edges);
                    error_count++;
                end
                assert (valid_pulses == int'(active_request.read_write)) else begin
                    $display("error %s valid pulses: expected %0d actual %0d", active_name,
                             int'(active_request.read_write), valid_pulses);
                    error_count++;
                end
            end
        end
        prev_busy         = busy;
        prev_serial_clock = serial_clock;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("Timeout, the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Something failed");
        $finish;
    end

endmodule

// File: spi_master.f
source/spi_master_pkg.sv
source/spi_request_stage.sv
source/spi_bit_sequencer.sv
source/spi_shift_unit.sv
source/spi_master.sv
sim/spi_slave_model.sv
sim/tb_spi_master.sv

// File: Bender.yml
package:
  name: spi_master

sources:
  - source/spi_master_pkg.sv
  - source/spi_request_stage.sv
  - source/spi_bit_sequencer.sv
  - source/spi_shift_unit.sv
  - source/spi_master.sv
  - target: test
    files:
      - sim/spi_slave_model.sv
      - sim/tb_spi_master.sv
